// ==== avmm_rdwr_if.sv ====
/*
 * Avalon-style register bus split into independent read and write halves.
 * Addresses are word addresses and responses carry no back-pressure.
 */
`timescale 1ns/1ps

interface avmm_rdwr_if;
    import csr_bridge_pkg::*;

    // Read request and its response
    logic rd_read;
    logic [avmm_addr_width-1:0] rd_address;
    logic rd_waitrequest;
    logic rd_readdatavalid;
    logic [data_width-1:0] rd_readdata;
    t_resp rd_response;

    // Write request, with the AXI ID riding along as user data
    logic wr_write;
    logic [avmm_addr_width-1:0] wr_address;
    logic [data_width-1:0] wr_writedata;
    logic [strb_width-1:0] wr_byteenable;
    logic [id_width-1:0] wr_user;
    logic wr_waitrequest;

    // Write response, the user field echoes wr_user
    logic wr_writeresponsevalid;
    t_resp wr_response;
    logic [id_width-1:0] wr_writeresponseuser;

    modport source
    (
        output rd_read, rd_address, wr_write, wr_address, wr_writedata, wr_byteenable, wr_user,
        input rd_waitrequest, rd_readdatavalid, rd_readdata, rd_response,
        input wr_waitrequest, wr_writeresponsevalid, wr_response, wr_writeresponseuser
    );

    modport sink
    (
        input rd_read, rd_address, wr_write, wr_address, wr_writedata, wr_byteenable, wr_user,
        output rd_waitrequest, rd_readdatavalid, rd_readdata, rd_response,
        output wr_waitrequest, wr_writeresponsevalid, wr_response, wr_writeresponseuser
    );

endinterface

// ==== axil_csr_top.sv ====
/*
 * CSR subsystem with a plain AXI4-lite port. There is no bready, so bvalid must be
 * taken in the cycle it is high.
 */
`timescale 1ns/1ps

module axil_csr_top
#(
    parameter int N_REGS = 16,
    parameter int RD_LATENCY = 2
)
(
    input  logic clk,
    input  logic reset_n,

    // Write address
    input  logic awvalid,
    output logic awready,
    input  logic [csr_bridge_pkg::axil_addr_width-1:0] awaddr,
    input  logic [csr_bridge_pkg::id_width-1:0] awid,

    // Write data
    input  logic wvalid,
    output logic wready,
    input  logic [csr_bridge_pkg::data_width-1:0] wdata,
    input  logic [csr_bridge_pkg::strb_width-1:0] wstrb,

    // Write response
    output logic bvalid,
    output csr_bridge_pkg::t_resp bresp,
    output logic [csr_bridge_pkg::id_width-1:0] bid,

    // Read address
    input  logic arvalid,
    output logic arready,
    input  logic [csr_bridge_pkg::axil_addr_width-1:0] araddr,
    input  logic [csr_bridge_pkg::id_width-1:0] arid,

    // Read data
    output logic rvalid,
    input  logic rready,
    output logic [csr_bridge_pkg::data_width-1:0] rdata,
    output csr_bridge_pkg::t_resp rresp,
    output logic [csr_bridge_pkg::id_width-1:0] rid
);

    axil_if axil_bus();
    avmm_rdwr_if avmm_bus();

    // Manager side of the AXI bus comes straight from the ports
    assign axil_bus.awvalid = awvalid;
    assign axil_bus.aw = '{addr: awaddr, id: awid};
    assign axil_bus.wvalid = wvalid;
    assign axil_bus.w = '{data: wdata, strb: wstrb};
    assign axil_bus.arvalid = arvalid;
    assign axil_bus.araddr = araddr;
    assign axil_bus.arid = arid;
    assign axil_bus.rready = rready;

    assign awready = axil_bus.awready;
    assign wready = axil_bus.wready;
    assign bvalid = axil_bus.bvalid;
    assign bresp = axil_bus.bresp;
    assign bid = axil_bus.bid;
    assign arready = axil_bus.arready;
    assign rvalid = axil_bus.rvalid;
    assign rdata = axil_bus.rdata;
    assign rresp = axil_bus.rresp;
    assign rid = axil_bus.rid;

    axil_to_avmm_rdwr axil_to_avmm_rdwr_i
    (
        .clk,
        .reset_n,
        .axil_source(axil_bus.subordinate),
        .avmm_sink(avmm_bus.source)
    );

    csr_regfile
    #(
        .N_REGS(N_REGS),
        .RD_LATENCY(RD_LATENCY)
    )
    csr_regfile_i
    (
        .clk,
        .reset_n,
        .avmm_source(avmm_bus.sink)
    );

endmodule

// ==== axil_csr_trace.txt ====
# op byte_addr data strb id expected_resp expected_rdata (all hex, op is W or R)
# Read lines ignore data and strb; write lines ignore expected_rdata
R 0000 00000000 0 1 0 c5a00001
W 0000 ffffffff f 2 0 00000000
R 0000 00000000 0 3 0 c5a00001
W 0004 12345678 f 4 0 00000000
R 0004 00000000 0 5 0 12345678
W 0004 aabbccdd 5 6 0 00000000
R 0004 00000000 0 7 0 12bb56dd
W 0008 cafef00d c 8 0 00000000
R 0008 00000000 0 9 0 cafe0000
W 0040 deadbeef f a 2 00000000
R 0040 00000000 0 b 2 00000000
W fffc 11111111 f c 2 00000000
R fffc 00000000 0 d 2 00000000
W 000c 01020304 f e 0 00000000
W 0010 05060708 f f 0 00000000
W 0014 090a0b0c 3 0 0 00000000
W 003c 0f0e0d0c f 1 0 00000000
R 000c 00000000 0 2 0 01020304
W 000c ff00ff00 a 3 0 00000000
R 0010 00000000 0 4 0 05060708
R 000c 00000000 0 5 0 ff02ff04
R 0014 00000000 0 6 0 00000b0c
W 0004 00000000 0 7 0 00000000
R 003c 00000000 0 8 0 0f0e0d0c
R 0004 00000000 0 9 0 12bb56dd
W 000b 00000077 1 a 0 00000000
R 000a 00000000 0 b 0 cafe0077
W 003f 99887766 2 c 0 00000000
R 003c 00000000 0 d 0 0f0e770c
R 0000 00000000 0 e 0 c5a00001
R 0038 00000000 0 f 0 00000000

// ==== axil_if.sv ====
/*
 * AXI4-lite bus with IDs. B has no bready, so the manager must take bvalid in any cycle.
 */
`timescale 1ns/1ps

interface axil_if;
    import csr_bridge_pkg::*;

    // Write address channel
    logic awvalid;
    logic awready;
    t_aw_payload aw;

    // Write data channel
    logic wvalid;
    logic wready;
    t_w_payload w;

    // Write response is a single-cycle pulse
    logic bvalid;
    t_resp bresp;
    logic [id_width-1:0] bid;

    // Read address channel
    logic arvalid;
    logic arready;
    logic [axil_addr_width-1:0] araddr;
    logic [id_width-1:0] arid;

    // Read data channel
    logic rvalid;
    logic rready;
    logic [data_width-1:0] rdata;
    t_resp rresp;
    logic [id_width-1:0] rid;

    // The side that issues requests
    modport manager
    (
        output awvalid, aw, wvalid, w, arvalid, araddr, arid, rready,
        input awready, wready, bvalid, bresp, bid, arready, rvalid, rdata, rresp, rid
    );

    // The side that serves requests
    modport subordinate
    (
        input awvalid, aw, wvalid, w, arvalid, araddr, arid, rready,
        output awready, wready, bvalid, bresp, bid, arready, rvalid, rdata, rresp, rid
    );

endinterface

// ==== axil_to_avmm_rdwr.sv ====
/*
 * AXI4-lite to split Avalon bridge. One read is outstanding at a time, writes have no
 * response flow control, and the low two byte-address bits are dropped.
 */
`timescale 1ns/1ps

module axil_to_avmm_rdwr
(
    input  logic clk,
    input  logic reset_n,

    axil_if.subordinate axil_source,
    avmm_rdwr_if.source avmm_sink
);
    import csr_bridge_pkg::*;

    // First AXI address bit that maps onto the word address
    localparam int addr_lsb = axil_addr_width - avmm_addr_width;

    // ==================================================================
    //  Reads
    // ==================================================================

    // Cleared from the ar transfer until the r transfer, which keeps the
    // single registered response slot from ever being overrun
    logic rd_not_busy;

    // ID of the read in flight, returned with its data
    logic [id_width-1:0] rd_id_held;

    always_comb
    begin
        axil_source.arready = !avmm_sink.rd_waitrequest && rd_not_busy;
        avmm_sink.rd_read = axil_source.arvalid && rd_not_busy;
        avmm_sink.rd_address = axil_source.araddr[addr_lsb +: avmm_addr_width];
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rd_not_busy <= 1'b1;
            axil_source.rvalid <= 1'b0;
        end
        else
        begin
            if (axil_source.rvalid && axil_source.rready)
            begin
                // Response taken, the next read may go
                rd_not_busy <= 1'b1;
                axil_source.rvalid <= 1'b0;
            end
            else if (axil_source.arvalid && axil_source.arready)
            begin
                rd_not_busy <= 1'b0;
            end

            // Data from the sink is held here until the manager raises rready
            if (avmm_sink.rd_readdatavalid)
            begin
                axil_source.rvalid <= 1'b1;
            end
        end
    end

    // Read payload
    always_ff @(posedge clk)
    begin
        if (axil_source.arvalid && axil_source.arready)
        begin
            rd_id_held <= axil_source.arid;
        end

        if (avmm_sink.rd_readdatavalid)
        begin
            axil_source.rdata <= avmm_sink.rd_readdata;
            axil_source.rresp <= avmm_sink.rd_response;
            axil_source.rid <= rd_id_held;
        end
    end

    // ==================================================================
    //  Writes
    // ==================================================================

    // Address and data arrive on independent channels, so each is queued
    // and the two heads are paired into one Avalon write
    t_aw_payload aw_head;
    t_w_payload w_head;
    logic aw_pending;
    logic w_pending;
    logic wr_issue;

    // Both heads leave their FIFOs on the cycle the write is accepted
    assign wr_issue = aw_pending && w_pending && !avmm_sink.wr_waitrequest;

    fifo2
    #(
        .T_PAYLOAD(t_aw_payload)
    )
    aw_fifo
    (
        .clk,
        .reset_n,
        .enq_data(axil_source.aw),
        .enq_en(axil_source.awvalid && axil_source.awready),
        .not_full(axil_source.awready),
        .first(aw_head),
        .deq_en(wr_issue),
        .not_empty(aw_pending)
    );

    fifo2
    #(
        .T_PAYLOAD(t_w_payload)
    )
    w_fifo
    (
        .clk,
        .reset_n,
        .enq_data(axil_source.w),
        .enq_en(axil_source.wvalid && axil_source.wready),
        .not_full(axil_source.wready),
        .first(w_head),
        .deq_en(wr_issue),
        .not_empty(w_pending)
    );

    always_comb
    begin
        avmm_sink.wr_write = aw_pending && w_pending;
        avmm_sink.wr_address = aw_head.addr[addr_lsb +: avmm_addr_width];
        avmm_sink.wr_writedata = w_head.data;
        avmm_sink.wr_byteenable = w_head.strb;
        avmm_sink.wr_user = aw_head.id;

        // The sink's response goes out as is; the user field already holds the ID
        axil_source.bvalid = avmm_sink.wr_writeresponsevalid;
        axil_source.bresp = avmm_sink.wr_response;
        axil_source.bid = avmm_sink.wr_writeresponseuser;
    end

endmodule

// ==== csr_bridge_pkg.sv ====
/*
 * Bus widths, response codes and channel payloads for the AXI4-lite CSR path.
 * Registers are 32-bit words, so the two low byte-address bits never reach the register bus.
 */
package csr_bridge_pkg;

    // AXI byte address and register-bus word address
    localparam int axil_addr_width = 16;
    localparam int avmm_addr_width = 14;

    // Data path is one 32-bit word with a strobe per byte
    localparam int data_width = 32;
    localparam int strb_width = 4;

    // Transaction ID carried on every request and echoed on every response
    localparam int id_width = 4;

    // AXI response encoding, only OKAY and SLVERR are produced
    typedef logic [1:0] t_resp;
    localparam t_resp resp_okay = 2'd0;
    localparam t_resp resp_slverr = 2'd2;

    // Write address channel payload
    typedef struct packed {
        logic [axil_addr_width-1:0] addr;
        logic [id_width-1:0] id;
    } t_aw_payload;

    // Write data channel payload
    typedef struct packed {
        logic [data_width-1:0] data;
        logic [strb_width-1:0] strb;
    } t_w_payload;

    // Register 0 reads as this identity word
    localparam logic [data_width-1:0] regfile_id_value = 32'hc5a0_0001;

endpackage

// ==== csr_regfile.sv ====
/*
 * CSR block on the split Avalon bus. Needs N_REGS >= 2 and RD_LATENCY >= 1.
 * Register 0 is a read-only identity word; addresses at or above N_REGS get SLVERR.
 */
`timescale 1ns/1ps

module csr_regfile
#(
    parameter int N_REGS = 16,
    parameter int RD_LATENCY = 2
)
(
    input  logic clk,
    input  logic reset_n,

    avmm_rdwr_if.sink avmm_source
);
    import csr_bridge_pkg::*;

    localparam int idx_width = $clog2(N_REGS);

    // Register 0 has no storage, it is a constant
    logic [data_width-1:0] regs [1:N_REGS-1];

    // ==================================================================
    //  Read pipeline
    // ==================================================================

    logic rd_accept;
    logic rd_in_range;
    logic [idx_width-1:0] rd_idx;
    logic [data_width-1:0] rd_word;

    logic [RD_LATENCY-1:0] rd_valid_pipe;
    logic [data_width-1:0] rd_data_pipe [RD_LATENCY];
    t_resp rd_resp_pipe [RD_LATENCY];

    // A read is taken every cycle
    assign avmm_source.rd_waitrequest = 1'b0;
    assign rd_accept = avmm_source.rd_read && !avmm_source.rd_waitrequest;

    assign rd_in_range = (avmm_source.rd_address < avmm_addr_width'(N_REGS));
    assign rd_idx = avmm_source.rd_address[idx_width-1:0];

    always_comb
    begin
        if (!rd_in_range)
            rd_word = '0;
        else if (rd_idx == '0)
            rd_word = regfile_id_value;
        else
            rd_word = regs[rd_idx];
    end

    // The valid bits shift alongside the data, several reads may be in flight
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rd_valid_pipe <= '0;
        end
        else
        begin
            rd_valid_pipe[0] <= rd_accept;
            for (int i = 1; i < RD_LATENCY; i++)
                rd_valid_pipe[i] <= rd_valid_pipe[i-1];
        end
    end

    always_ff @(posedge clk)
    begin
        rd_data_pipe[0] <= rd_word;
        rd_resp_pipe[0] <= rd_in_range ? resp_okay : resp_slverr;
        for (int i = 1; i < RD_LATENCY; i++)
        begin
            rd_data_pipe[i] <= rd_data_pipe[i-1];
            rd_resp_pipe[i] <= rd_resp_pipe[i-1];
        end
    end

    assign avmm_source.rd_readdatavalid = rd_valid_pipe[RD_LATENCY-1];
    assign avmm_source.rd_readdata = rd_data_pipe[RD_LATENCY-1];
    assign avmm_source.rd_response = rd_resp_pipe[RD_LATENCY-1];

    // ==================================================================
    //  Write port
    // ==================================================================

    logic wr_accept;
    logic wr_in_range;
    logic [idx_width-1:0] wr_idx;

    // The stall cycle after a write is the same cycle its response goes out
    assign avmm_source.wr_waitrequest = avmm_source.wr_writeresponsevalid;
    assign wr_accept = avmm_source.wr_write && !avmm_source.wr_waitrequest;

    assign wr_in_range = (avmm_source.wr_address < avmm_addr_width'(N_REGS));
    assign wr_idx = avmm_source.wr_address[idx_width-1:0];

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            for (int i = 1; i < N_REGS; i++)
                regs[i] <= '0;
            avmm_source.wr_writeresponsevalid <= 1'b0;
        end
        else
        begin
            avmm_source.wr_writeresponsevalid <= wr_accept;

            // Only enabled byte lanes change; writes to register 0 are dropped
            if (wr_accept && wr_in_range && (wr_idx != '0))
            begin
                for (int b = 0; b < strb_width; b++)
                    if (avmm_source.wr_byteenable[b])
                        regs[wr_idx][8*b +: 8] <= avmm_source.wr_writedata[8*b +: 8];
            end
        end
    end

    // Response code and echoed ID for the accepted write
    always_ff @(posedge clk)
    begin
        if (wr_accept)
        begin
            avmm_source.wr_response <= wr_in_range ? resp_okay : resp_slverr;
            avmm_source.wr_writeresponseuser <= avmm_source.wr_user;
        end
    end

endmodule

// ==== fifo2.sv ====
/*
 * Two-entry FIFO with a combinational head. enq_en is ignored while full and
 * deq_en is ignored while empty, so a full FIFO cannot enqueue and dequeue together.
 */
`timescale 1ns/1ps

module fifo2
#(
    parameter type T_PAYLOAD = logic
)
(
    input  logic clk,
    input  logic reset_n,

    input  T_PAYLOAD enq_data,
    input  logic enq_en,
    output logic not_full,

    output T_PAYLOAD first,
    input  logic deq_en,
    output logic not_empty
);

    // Entry 0 is always the head, entry 1 the tail when two are held
    T_PAYLOAD entry [2];
    logic [1:0] n_entries;

    logic do_enq;
    logic do_deq;

    assign not_full = (n_entries != 2'd2);
    assign not_empty = (n_entries != 2'd0);
    assign first = entry[0];

    assign do_enq = enq_en && not_full;
    assign do_deq = deq_en && not_empty;

    // Occupancy
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            n_entries <= 2'd0;
        end
        else
        begin
            n_entries <= n_entries + 2'(do_enq) - 2'(do_deq);
        end
    end

    // Storage. A dequeue shifts the tail into the head slot, and a new entry lands
    // in the first slot that is free after that shift
    always_ff @(posedge clk)
    begin
        if (do_deq)
        begin
            entry[0] <= entry[1];
        end

        if (do_enq)
        begin
            if ((n_entries == 2'd0) || (do_deq && (n_entries == 2'd1)))
            begin
                entry[0] <= enq_data;
            end
            else
            begin
                entry[1] <= enq_data;
            end
        end
    end

endmodule

// ==== project.f ====
csr_bridge_pkg.sv
axil_if.sv
avmm_rdwr_if.sv
fifo2.sv
axil_to_avmm_rdwr.sv
csr_regfile.sv
axil_csr_top.sv
tb_axil_csr_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_axil_csr_top -f project.f -o sim_tb

# The simulator exits non-zero on a failed check, the log decides the result
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log || ! grep -q "RESULT: PASS" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

// ==== tb_axil_csr_top.sv ====
/*
 * Trace-driven testbench for the AXI4-lite CSR subsystem. Runs from the project root and
 * issues one transaction at a time, so every bvalid pulse is caught.
 */
`timescale 1ns/1ps

module tb_axil_csr_top;
    import csr_bridge_pkg::*;

    localparam int max_lines = 64;
    localparam int cycles_per_line = 40;

    // Inputs change 1 ns after the rising edge and outputs are read at mid-cycle
    localparam int drive_delay = 1;
    localparam int sample_delay = 48;

    logic clk = 1'b0;
    logic reset_n;
    logic awvalid;
    logic awready;
    logic [axil_addr_width-1:0] awaddr;
    logic [id_width-1:0] awid;
    logic wvalid;
    logic wready;
    logic [data_width-1:0] wdata;
    logic [strb_width-1:0] wstrb;
    logic bvalid;
    t_resp bresp;
    logic [id_width-1:0] bid;
    logic arvalid;
    logic arready;
    logic [axil_addr_width-1:0] araddr;
    logic [id_width-1:0] arid;
    logic rvalid;
    logic rready;
    logic [data_width-1:0] rdata;
    t_resp rresp;
    logic [id_width-1:0] rid;

    // One entry per trace line
    byte tr_op [max_lines];
    logic [axil_addr_width-1:0] tr_addr [max_lines];
    logic [data_width-1:0] tr_data [max_lines];
    logic [strb_width-1:0] tr_strb [max_lines];
    logic [id_width-1:0] tr_id [max_lines];
    t_resp tr_resp [max_lines];
    logic [data_width-1:0] tr_rdata [max_lines];
    int n_trans = 0;

    int cycle_count = 0;
    int cycle_limit = 100000;

    axil_csr_top
    #(
        .N_REGS(16),
        .RD_LATENCY(2)
    )
    axil_csr_top_i
    (
        .clk, .reset_n,
        .awvalid, .awready, .awaddr, .awid,
        .wvalid, .wready, .wdata, .wstrb,
        .bvalid, .bresp, .bid,
        .arvalid, .arready, .araddr, .arid,
        .rvalid, .rready, .rdata, .rresp, .rid
    );

    always #50 clk = ~clk;

    // ======================================================================
    //  Run control
    // ======================================================================

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "Run stopped at cycle %0d", cycle_count);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
            fail_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected));
    endtask

    // Every trace line gets a fixed budget of cycles, plus a margin for reset
    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count > cycle_limit)
            fail_run($sformatf("Timeout: the trace did not finish within %0d cycles", cycle_limit));
    end

    task automatic load_trace();
        int fd;
        int n_fields;
        string line;
        logic [axil_addr_width-1:0] addr;
        logic [data_width-1:0] data;
        logic [strb_width-1:0] strb;
        logic [id_width-1:0] id;
        t_resp resp;
        logic [data_width-1:0] rd_exp;
        fd = $fopen("axil_csr_trace.txt", "r");
        if (fd == 0)
            fail_run("Could not open the trace file axil_csr_trace.txt");
        while ($fgets(line, fd) > 0)
        begin
            // Comment and blank lines carry no transaction
            if ((line.len() < 2) || (line.getc(0) == "#"))
                continue;
            if (n_trans == max_lines)
                fail_run("The trace file holds more transactions than the testbench can store");
            n_fields = $sscanf(line.substr(2, line.len() - 1), "%h %h %h %h %h %h",
                               addr, data, strb, id, resp, rd_exp);
            if ((n_fields != 6) || ((line.getc(0) != "W") && (line.getc(0) != "R")))
                fail_run($sformatf("Trace transaction %0d is malformed", n_trans + 1));
            tr_op[n_trans] = line.getc(0);
            tr_addr[n_trans] = addr;
            tr_data[n_trans] = data;
            tr_strb[n_trans] = strb;
            tr_id[n_trans] = id;
            tr_resp[n_trans] = resp;
            tr_rdata[n_trans] = rd_exp;
            n_trans++;
        end
        $fclose(fd);
        if (n_trans == 0)
            fail_run("The trace file holds no transactions");
    endtask

    // ======================================================================
    //  Channel drivers
    // ======================================================================

    // Waits whole cycles and comes back at the drive point
    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #drive_delay;
        end
    endtask

    task automatic send_aw(input int delay);
        logic taken;
        idle_cycles(delay);
        awvalid = 1'b1;
        taken = 1'b0;
        // The transfer happens at the edge that follows a mid-cycle awready
        while (!taken)
        begin
            #sample_delay;
            taken = awready;
            @(posedge clk);
            #drive_delay;
        end
        awvalid = 1'b0;
    endtask

    task automatic send_w(input int delay);
        logic taken;
        idle_cycles(delay);
        wvalid = 1'b1;
        taken = 1'b0;
        while (!taken)
        begin
            #sample_delay;
            taken = wready;
            @(posedge clk);
            #drive_delay;
        end
        wvalid = 1'b0;
    endtask

    task automatic write_register(input int k);
        logic seen;
        t_resp resp_seen;
        logic [id_width-1:0] id_seen;
        int aw_delay;
        int w_delay;
        aw_delay = $urandom_range(4, 0);
        w_delay = $urandom_range(4, 0);
        awaddr = tr_addr[k];
        awid = tr_id[k];
        wdata = tr_data[k];
        wstrb = tr_strb[k];
        // Address and data go up independently, in either order
        fork
            send_aw(aw_delay);
            send_w(w_delay);
        join
        // bvalid is a single-cycle pulse, so it is looked for every cycle
        seen = 1'b0;
        while (!seen)
        begin
            #sample_delay;
            if (bvalid)
            begin
                seen = 1'b1;
                resp_seen = bresp;
                id_seen = bid;
            end
            @(posedge clk);
            #drive_delay;
        end
        check_value("bresp", 32'(resp_seen), 32'(tr_resp[k]));
        check_value("bid", 32'(id_seen), 32'(tr_id[k]));
        // The pulse is gone one cycle later
        #sample_delay;
        check_value("bvalid", 32'(bvalid), 32'd0);
        @(posedge clk);
        #drive_delay;
    endtask

    task automatic read_register(input int k);
        logic taken;
        logic [data_width-1:0] held;
        int stall;
        araddr = tr_addr[k];
        arid = tr_id[k];
        arvalid = 1'b1;
        taken = 1'b0;
        while (!taken)
        begin
            #sample_delay;
            taken = arready;
            @(posedge clk);
            #drive_delay;
        end
        arvalid = 1'b0;
        // rready stays low until the data shows up
        // No new read is let in while this one is outstanding
        #sample_delay;
        while (!rvalid)
        begin
            check_value("arready", 32'(arready), 32'd0);
            @(posedge clk);
            #(drive_delay + sample_delay);
        end
        held = rdata;
        // A stalled response must hold still
        stall = $urandom_range(3, 0);
        repeat (stall)
        begin
            @(posedge clk);
            #(drive_delay + sample_delay);
            check_value("rvalid", 32'(rvalid), 32'd1);
            check_value("rdata", rdata, held);
            check_value("arready", 32'(arready), 32'd0);
        end
        @(posedge clk);
        #drive_delay;
        rready = 1'b1;
        #sample_delay;
        check_value("rvalid", 32'(rvalid), 32'd1);
        check_value("arready", 32'(arready), 32'd0);
        check_value("rdata", rdata, tr_rdata[k]);
        check_value("rresp", 32'(rresp), 32'(tr_resp[k]));
        check_value("rid", 32'(rid), 32'(tr_id[k]));
        @(posedge clk);
        #drive_delay;
        rready = 1'b0;
    endtask

    // ======================================================================
    //  Main sequence
    // ======================================================================

    initial
    begin
        reset_n = 1'b0;
        awvalid = 1'b0;
        awaddr = '0;
        awid = '0;
        wvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        arvalid = 1'b0;
        araddr = '0;
        arid = '0;
        rready = 1'b0;
        void'($urandom(32'h9a19));

        load_trace();
        cycle_limit = cycles_per_line * n_trans + 10;

        repeat (3) @(posedge clk);
        #drive_delay;
        reset_n = 1'b1;

        // Straight out of reset nothing is pending and every request channel is open
        #sample_delay;
        check_value("rvalid", 32'(rvalid), 32'd0);
        check_value("bvalid", 32'(bvalid), 32'd0);
        check_value("arready", 32'(arready), 32'd1);
        check_value("awready", 32'(awready), 32'd1);
        check_value("wready", 32'(wready), 32'd1);
        @(posedge clk);
        #drive_delay;

        for (int k = 0; k < n_trans; k++)
        begin
            if (tr_op[k] == "W")
                write_register(k);
            else
                read_register(k);
        end

        $display("All %0d trace transactions matched", n_trans);
        $display("RESULT: PASS");
        $finish;
    end

endmodule
